// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [31:0]     addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_index_t;

    // major opcodes kept in this core
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_e;

    // alu funct3
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;

    localparam addr_t pc_start   = 32'h0000_0000;
    localparam addr_t inst_bytes = 32'd4;

endpackage

`default_nettype wire

// File: verilog/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    // alu operation
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    // br_always covers jal
    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_always
    } branch_e;

    // source of the register write value
    typedef enum logic [1:0] {
        wb_alu,
        wb_imm,
        wb_link
    } wb_sel_e;

endpackage

`default_nettype wire

// File: verilog/rv_decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rv_decode_if;

    logic                    valid;
    rv_isa_pkg::addr_t       pc;
    rv_isa_pkg::word_t       rs1_data;
    rv_isa_pkg::word_t       rs2_data;
    rv_isa_pkg::word_t       imm;
    logic                    use_imm;
    rv_ctrl_pkg::alu_op_e    alu_op;
    rv_ctrl_pkg::branch_e    branch;
    rv_isa_pkg::reg_index_t  rd;
    logic                    rd_we;
    rv_ctrl_pkg::wb_sel_e    wb_sel;

    modport decoder (
        output valid, pc, rs1_data, rs2_data, imm, use_imm,
        output alu_op, branch, rd, rd_we, wb_sel
    );

    // operands and branch control
    modport execute (
        input valid, pc, rs1_data, rs2_data, imm, use_imm, alu_op, branch
    );

    // result select and commit
    modport writeback (
        input valid, pc, imm, rd, rd_we, wb_sel
    );

endinterface

`default_nettype wire

// File: verilog/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
    input  logic               inst_selfdefine,
    input  logic               reset,
    input  logic               valid,
    input  logic               redirect,
    input  rv_isa_pkg::addr_t  target,
    output rv_isa_pkg::addr_t  pc
);

    rv_isa_pkg::addr_t next_pc;

    // taken branch or jal, else sequential
    always_comb begin
        if (redirect) begin
            next_pc = target;
        end else begin
            next_pc = pc + rv_isa_pkg::inst_bytes;
        end
    end

    // pc holds while no instruction is presented
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            pc <= rv_isa_pkg::pc_start;
        end else if (valid) begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  rv_isa_pkg::inst_t       inst,
    input  logic                    inst_valid,
    input  rv_isa_pkg::addr_t       pc,
    output rv_isa_pkg::reg_index_t  rs1_index,
    output rv_isa_pkg::reg_index_t  rs2_index,
    input  rv_isa_pkg::word_t       rs1_data,
    input  rv_isa_pkg::word_t       rs2_data,
    rv_decode_if.decoder            dec
);

    rv_isa_pkg::opcode_e  opcode;
    logic [2:0]           funct3;
    logic                 alt_funct;
    rv_isa_pkg::word_t    imm_i;
    rv_isa_pkg::word_t    imm_b;
    rv_isa_pkg::word_t    imm_j;
    rv_isa_pkg::word_t    imm_u;

    // funct3 to alu op, alt bit selects sub / sra
    function automatic rv_ctrl_pkg::alu_op_e alu_map(
        input logic [2:0] f3,
        input logic       alt,
        input logic       is_reg
    );
        rv_ctrl_pkg::alu_op_e op;
        case (f3)
            rv_isa_pkg::f3_add:  op = (alt && is_reg) ? rv_ctrl_pkg::alu_sub
                                                      : rv_ctrl_pkg::alu_add;
            rv_isa_pkg::f3_sll:  op = rv_ctrl_pkg::alu_sll;
            rv_isa_pkg::f3_slt:  op = rv_ctrl_pkg::alu_slt;
            rv_isa_pkg::f3_sltu: op = rv_ctrl_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:  op = rv_ctrl_pkg::alu_xor;
            rv_isa_pkg::f3_srl:  op = alt ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
            rv_isa_pkg::f3_or:   op = rv_ctrl_pkg::alu_or;
            default:             op = rv_ctrl_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign opcode    = rv_isa_pkg::opcode_e'(inst[6:0]);
    assign funct3    = inst[14:12];
    assign alt_funct = inst[30];
    assign rs1_index = inst[19:15];
    assign rs2_index = inst[24:20];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    assign dec.valid    = inst_valid;
    assign dec.pc       = pc;
    assign dec.rs1_data = rs1_data;
    assign dec.rs2_data = rs2_data;
    assign dec.rd       = inst[11:7];

    always_comb begin
        dec.imm     = imm_i;
        dec.use_imm = 1'b0;
        dec.alu_op  = rv_ctrl_pkg::alu_add;
        dec.branch  = rv_ctrl_pkg::br_none;
        dec.rd_we   = 1'b0;
        dec.wb_sel  = rv_ctrl_pkg::wb_alu;
        case (opcode)
            rv_isa_pkg::op_reg: begin
                dec.rd_we  = 1'b1;
                dec.alu_op = alu_map(funct3, alt_funct, 1'b1);
            end
            rv_isa_pkg::op_imm: begin
                dec.rd_we   = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_op  = alu_map(funct3, alt_funct, 1'b0);
            end
            rv_isa_pkg::op_lui: begin
                dec.rd_we  = 1'b1;
                dec.imm    = imm_u;
                dec.wb_sel = rv_ctrl_pkg::wb_imm;
            end
            rv_isa_pkg::op_branch: begin
                dec.imm = imm_b;
                case (funct3)
                    rv_isa_pkg::f3_beq: dec.branch = rv_ctrl_pkg::br_eq;
                    rv_isa_pkg::f3_bne: dec.branch = rv_ctrl_pkg::br_ne;
                    rv_isa_pkg::f3_blt: dec.branch = rv_ctrl_pkg::br_lt;
                    rv_isa_pkg::f3_bge: dec.branch = rv_ctrl_pkg::br_ge;
                    default:            dec.branch = rv_ctrl_pkg::br_none;
                endcase
            end
            rv_isa_pkg::op_jal: begin
                dec.rd_we  = 1'b1;
                dec.imm    = imm_j;
                dec.branch = rv_ctrl_pkg::br_always;
                dec.wb_sel = rv_ctrl_pkg::wb_link;
            end
            // unknown opcode just steps the pc
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                    inst_selfdefine,
    input  logic                    reset,
    input  rv_isa_pkg::reg_index_t  rs1_index,
    input  rv_isa_pkg::reg_index_t  rs2_index,
    output rv_isa_pkg::word_t       rs1_data,
    output rv_isa_pkg::word_t       rs2_data,
    input  logic                    we,
    input  rv_isa_pkg::reg_index_t  rd,
    input  rv_isa_pkg::word_t       rd_data
);

    rv_isa_pkg::word_t regs [0:31];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_index == 5'd0) ? '0 : regs[rs1_index];
    assign rs2_data = (rs2_index == 5'd0) ? '0 : regs[rs2_index];

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    rv_decode_if.execute        dec,
    output rv_isa_pkg::word_t   alu_result,
    output logic                redirect,
    output rv_isa_pkg::addr_t   target
);

    rv_isa_pkg::word_t  op_a;
    rv_isa_pkg::word_t  op_b;
    logic [4:0]         shamt;
    logic               rs_eq;
    logic               rs_lt;
    logic               taken;

    assign op_a  = dec.rs1_data;
    assign op_b  = dec.use_imm ? dec.imm : dec.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_ctrl_pkg::alu_add:  alu_result = op_a + op_b;
            rv_ctrl_pkg::alu_sub:  alu_result = op_a - op_b;
            rv_ctrl_pkg::alu_and:  alu_result = op_a & op_b;
            rv_ctrl_pkg::alu_or:   alu_result = op_a | op_b;
            rv_ctrl_pkg::alu_xor:  alu_result = op_a ^ op_b;
            rv_ctrl_pkg::alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_ctrl_pkg::alu_sltu: alu_result = {31'b0, op_a < op_b};
            rv_ctrl_pkg::alu_sll:  alu_result = op_a << shamt;
            rv_ctrl_pkg::alu_srl:  alu_result = op_a >> shamt;
            rv_ctrl_pkg::alu_sra:  alu_result = rv_isa_pkg::word_t'($signed(op_a) >>> shamt);
            default:               alu_result = op_a + op_b;
        endcase
    end

    // branch compare always uses rs2, never the immediate
    assign rs_eq = (dec.rs1_data == dec.rs2_data);
    assign rs_lt = ($signed(dec.rs1_data) < $signed(dec.rs2_data));

    always_comb begin
        case (dec.branch)
            rv_ctrl_pkg::br_eq:     taken = rs_eq;
            rv_ctrl_pkg::br_ne:     taken = !rs_eq;
            rv_ctrl_pkg::br_lt:     taken = rs_lt;
            rv_ctrl_pkg::br_ge:     taken = !rs_lt;
            rv_ctrl_pkg::br_always: taken = 1'b1;
            default:                taken = 1'b0;
        endcase
    end

    assign redirect = dec.valid && taken;
    assign target   = dec.pc + dec.imm;

endmodule

`default_nettype wire

// File: verilog/rv_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module rv_writeback (
    input  logic                    inst_selfdefine,
    input  logic                    reset,
    rv_decode_if.writeback          dec,
    input  rv_isa_pkg::word_t       alu_result,
    output logic                    rf_we,
    output rv_isa_pkg::reg_index_t  rf_rd,
    output rv_isa_pkg::word_t       rf_data,
    output logic                    commit_valid,
    output rv_isa_pkg::addr_t       commit_pc,
    output logic                    commit_we,
    output rv_isa_pkg::reg_index_t  commit_rd,
    output rv_isa_pkg::word_t       commit_data
);

    always_comb begin
        case (dec.wb_sel)
            rv_ctrl_pkg::wb_imm:  rf_data = dec.imm;
            rv_ctrl_pkg::wb_link: rf_data = dec.pc + rv_isa_pkg::inst_bytes;
            default:              rf_data = alu_result;
        endcase
    end

    assign rf_we = dec.valid && dec.rd_we;
    assign rf_rd = dec.rd;

    // commit report, one cycle behind the write
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            commit_valid <= 1'b0;
            commit_we    <= 1'b0;
        end else begin
            commit_valid <= dec.valid;
            if (dec.valid) begin
                commit_we <= dec.rd_we;
            end
        end
    end

    always_ff @(posedge inst_selfdefine) begin
        if (dec.valid) begin
            commit_pc   <= dec.pc;
            commit_rd   <= dec.rd;
            commit_data <= rf_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                    inst_selfdefine,
    input  logic                    reset,
    input  rv_isa_pkg::inst_t       inst,
    input  logic                    inst_valid,
    output rv_isa_pkg::addr_t       pc,
    output logic                    commit_valid,
    output rv_isa_pkg::addr_t       commit_pc,
    output logic                    commit_we,
    output rv_isa_pkg::reg_index_t  commit_rd,
    output rv_isa_pkg::word_t       commit_data
);

    rv_isa_pkg::reg_index_t  rs1_index;
    rv_isa_pkg::reg_index_t  rs2_index;
    rv_isa_pkg::word_t       rs1_data;
    rv_isa_pkg::word_t       rs2_data;
    logic                    redirect;
    rv_isa_pkg::addr_t       target;
    rv_isa_pkg::word_t       alu_result;
    logic                    rf_we;
    rv_isa_pkg::reg_index_t  rf_rd;
    rv_isa_pkg::word_t       rf_data;

    // decoded instruction bundle
    rv_decode_if dec_bus ();

    rv_fetch u_rv_fetch (
        .inst_selfdefine( inst_selfdefine ),
        .reset( reset ),
        .valid( inst_valid ),
        .redirect( redirect ),
        .target( target ),
        .pc( pc )
    );

    rv_decode u_rv_decode (
        .inst( inst ),
        .inst_valid( inst_valid ),
        .pc( pc ),
        .rs1_index( rs1_index ),
        .rs2_index( rs2_index ),
        .rs1_data( rs1_data ),
        .rs2_data( rs2_data ),
        .dec( dec_bus.decoder )
    );

    rv_regfile u_rv_regfile (
        .inst_selfdefine( inst_selfdefine ),
        .reset( reset ),
        .rs1_index( rs1_index ),
        .rs2_index( rs2_index ),
        .rs1_data( rs1_data ),
        .rs2_data( rs2_data ),
        .we( rf_we ),
        .rd( rf_rd ),
        .rd_data( rf_data )
    );

    rv_execute u_rv_execute (
        .dec( dec_bus.execute ),
        .alu_result( alu_result ),
        .redirect( redirect ),
        .target( target )
    );

    rv_writeback u_rv_writeback (
        .inst_selfdefine( inst_selfdefine ),
        .reset( reset ),
        .dec( dec_bus.writeback ),
        .alu_result( alu_result ),
        .rf_we( rf_we ),
        .rf_rd( rf_rd ),
        .rf_data( rf_data ),
        .commit_valid( commit_valid ),
        .commit_pc( commit_pc ),
        .commit_we( commit_we ),
        .commit_rd( commit_rd ),
        .commit_data( commit_data )
    );

endmodule

`default_nettype wire

// File: dv/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int max_entries  = 32;
    localparam int reset_cycles = 5;

    logic                    inst_selfdefine;
    logic                    reset;
    rv_isa_pkg::inst_t       inst;
    logic                    inst_valid;
    rv_isa_pkg::addr_t       pc;
    logic                    commit_valid;
    rv_isa_pkg::addr_t       commit_pc;
    logic                    commit_we;
    rv_isa_pkg::reg_index_t  commit_rd;
    rv_isa_pkg::word_t       commit_data;

    // program in execution order, one row per accepted instruction
    string                   prog_name [max_entries];
    rv_isa_pkg::inst_t       prog_inst [max_entries];
    int                      prog_idle [max_entries];
    rv_isa_pkg::addr_t       exp_pc    [max_entries];
    logic                    exp_we    [max_entries];
    rv_isa_pkg::reg_index_t  exp_rd    [max_entries];
    rv_isa_pkg::word_t       exp_data  [max_entries];
    int                      n_entries;
    int                      issued;
    int                      committed;
    int                      value_errors;
    int                      other_errors;
    int                      cycles;
    int                      cycle_limit;

    rv_core u_rv_core (.*);

    initial begin
        inst_selfdefine = 1'b0;
        forever begin
            #50 inst_selfdefine = ~inst_selfdefine;
        end
    end

    function automatic rv_isa_pkg::inst_t encode_r(int f3, int alt, int rd, int rs1, int rs2);
        return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_isa_pkg::op_reg};
    endfunction

    function automatic rv_isa_pkg::inst_t encode_i(int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], rv_isa_pkg::op_imm};
    endfunction

    function automatic rv_isa_pkg::inst_t encode_u(int rd, int imm);
        return {imm[19:0], rd[4:0], rv_isa_pkg::op_lui};
    endfunction

    function automatic rv_isa_pkg::inst_t encode_b(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                rv_isa_pkg::op_branch};
    endfunction

    function automatic rv_isa_pkg::inst_t encode_j(int rd, int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_isa_pkg::op_jal};
    endfunction

    task automatic add_entry(string name, rv_isa_pkg::inst_t word, int idle,
                             rv_isa_pkg::addr_t pc_v, logic we, int rd, rv_isa_pkg::word_t data);
        prog_name[n_entries] = name;
        prog_inst[n_entries] = word;
        prog_idle[n_entries] = idle;
        exp_pc[n_entries]    = pc_v;
        exp_we[n_entries]    = we;
        exp_rd[n_entries]    = rd[4:0];
        exp_data[n_entries]  = data;
        n_entries++;
    endtask

    task automatic build_table();
        add_entry("addi x1", encode_i(0, 1, 0, 5), 2, 'h00, 1'b1, 1, 'h5);
        add_entry("addi x2", encode_i(0, 2, 0, -3), 0, 'h04, 1'b1, 2, 'hffff_fffd);
        add_entry("lui x3", encode_u(3, 'h80000), 0, 'h08, 1'b1, 3, 'h8000_0000);
        add_entry("addi x4", encode_i(0, 4, 0, 33), 0, 'h0c, 1'b1, 4, 'h21);
        add_entry("add x5", encode_r(0, 0, 5, 1, 2), 1, 'h10, 1'b1, 5, 'h2);
        add_entry("sub x6", encode_r(0, 1, 6, 2, 1), 0, 'h14, 1'b1, 6, 'hffff_fff8);
        add_entry("and x7", encode_r(7, 0, 7, 1, 4), 0, 'h18, 1'b1, 7, 'h1);
        add_entry("or x8", encode_r(6, 0, 8, 1, 3), 0, 'h1c, 1'b1, 8, 'h8000_0005);
        add_entry("xor x9", encode_r(4, 0, 9, 2, 1), 0, 'h20, 1'b1, 9, 'hffff_fff8);
        add_entry("slt x10", encode_r(2, 0, 10, 2, 1), 0, 'h24, 1'b1, 10, 'h1);
        add_entry("sltu x11", encode_r(3, 0, 11, 2, 1), 0, 'h28, 1'b1, 11, 'h0);
        add_entry("sll x12", encode_r(1, 0, 12, 1, 4), 0, 'h2c, 1'b1, 12, 'ha);
        add_entry("srl x13", encode_r(5, 0, 13, 3, 4), 0, 'h30, 1'b1, 13, 'h4000_0000);
        add_entry("sra x14", encode_r(5, 1, 14, 3, 4), 0, 'h34, 1'b1, 14, 'hc000_0000);
        add_entry("add x15", encode_r(0, 0, 15, 3, 3), 0, 'h38, 1'b1, 15, 'h0);
        add_entry("srai x16", encode_i(5, 16, 2, 'h401), 0, 'h3c, 1'b1, 16, 'hffff_fffe);
        add_entry("addi x0", encode_i(0, 0, 1, 7), 0, 'h40, 1'b1, 0, 'hc);
        add_entry("add x17", encode_r(0, 0, 17, 0, 1), 0, 'h44, 1'b1, 17, 'h5);
        // branches, taken then not taken
        add_entry("beq t", encode_b(0, 1, 17, 8), 0, 'h48, 1'b0, 0, 'h0);
        add_entry("beq nt", encode_b(0, 1, 2, 8), 0, 'h50, 1'b0, 0, 'h0);
        add_entry("bne t", encode_b(1, 1, 2, 8), 0, 'h54, 1'b0, 0, 'h0);
        add_entry("bne nt", encode_b(1, 1, 17, 8), 0, 'h5c, 1'b0, 0, 'h0);
        add_entry("blt t", encode_b(4, 2, 1, 8), 0, 'h60, 1'b0, 0, 'h0);
        add_entry("blt nt", encode_b(4, 1, 2, 8), 0, 'h68, 1'b0, 0, 'h0);
        add_entry("bge t", encode_b(5, 1, 2, 12), 0, 'h6c, 1'b0, 0, 'h0);
        add_entry("bge nt", encode_b(5, 2, 1, 8), 0, 'h78, 1'b0, 0, 'h0);
        add_entry("jal x18", encode_j(18, 16), 0, 'h7c, 1'b1, 18, 'h80);
        // backward jump into the slot skipped by the first beq
        add_entry("jal x19", encode_j(19, -64), 0, 'h8c, 1'b1, 19, 'h90);
        add_entry("add x20", encode_r(0, 0, 20, 18, 19), 3, 'h4c, 1'b1, 20, 'h110);
        add_entry("sub x21", encode_r(0, 1, 21, 20, 19), 0, 'h50, 1'b1, 21, 'h80);
    endtask

    task automatic check_pc(string name, rv_isa_pkg::addr_t exp, rv_isa_pkg::addr_t act);
        if (act !== exp) begin
            $display("** Error %s pc: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_we(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error %s we: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_rd(string name, rv_isa_pkg::reg_index_t exp,
                            rv_isa_pkg::reg_index_t act);
        if (act !== exp) begin
            $display("** Error %s rd: expected %0d, actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_data(string name, rv_isa_pkg::word_t exp, rv_isa_pkg::word_t act);
        if (act !== exp) begin
            $display("** Error %s data: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    // commit outputs settle after the rising edge
    always @(negedge inst_selfdefine) begin
        if (!reset && commit_valid) begin
            if (committed >= issued) begin
                $display("unexpected commit at pc %h with no instruction outstanding", commit_pc);
                other_errors++;
            end else begin
                check_pc(prog_name[committed], exp_pc[committed], commit_pc);
                check_we(prog_name[committed], exp_we[committed], commit_we);
                if (exp_we[committed]) begin
                    check_rd(prog_name[committed], exp_rd[committed], commit_rd);
                    check_data(prog_name[committed], exp_data[committed], commit_data);
                end
                committed++;
            end
        end
    end

    // instructions taken by the core
    always @(posedge inst_selfdefine) begin
        if (!reset && inst_valid) begin
            issued++;
        end
    end

    always @(posedge inst_selfdefine) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions committed",
                     cycles, committed, n_entries);
            other_errors++;
            finish_run();
        end
    end

    initial begin
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        n_entries    = 0;
        issued       = 0;
        committed    = 0;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        build_table();
        cycle_limit = n_entries + reset_cycles + 20;
        for (int i = 0; i < n_entries; i++) begin
            cycle_limit += prog_idle[i];
        end
        repeat (reset_cycles) @(posedge inst_selfdefine);
        @(negedge inst_selfdefine);
        reset = 1'b0;
        check_pc("reset", rv_isa_pkg::pc_start, pc);
        for (int i = 0; i < n_entries; i++) begin
            repeat (prog_idle[i]) begin
                @(negedge inst_selfdefine);
                inst_valid = 1'b0;
                inst       = '0;
                check_pc(prog_name[i], exp_pc[i], pc);
            end
            @(negedge inst_selfdefine);
            check_pc(prog_name[i], exp_pc[i], pc);
            inst       = prog_inst[i];
            inst_valid = 1'b1;
        end
        @(negedge inst_selfdefine);
        inst_valid = 1'b0;
        inst       = '0;
        wait (committed == n_entries);
        // a few quiet cycles to catch stray commits
        repeat (3) @(negedge inst_selfdefine);
        finish_run();
    end

endmodule

`default_nettype wire

// File: all.f
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/rv_decode_if.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_writeback.sv
verilog/rv_core.sv
dv/tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f all.f

sim:
	verilator --binary --timescale 1ns/1ps --top-module $(TOP) -f all.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
